// ==== letc_pkg.sv ====
// LETC peripheral subsystem package: bus widths, address map, register offsets, target codes
`default_nettype none

package letc_pkg;

    localparam int ADDR_W   = 16;   // Byte address
    localparam int DATA_W   = 32;
    localparam int OFFSET_W = 4;    // Register offset inside a target window

    // ACLINT map
    localparam logic [ADDR_W-1:0] ADDR_MSIP        = 16'h0000;   // Bit 0 only
    localparam logic [ADDR_W-1:0] ADDR_MTIMECMP_LO = 16'h4000;
    localparam logic [ADDR_W-1:0] ADDR_MTIMECMP_HI = 16'h4004;
    localparam logic [ADDR_W-1:0] ADDR_MTIME_LO    = 16'hBFF8;
    localparam logic [ADDR_W-1:0] ADDR_MTIME_HI    = 16'hBFFC;

    // GPIO map
    localparam logic [ADDR_W-1:0] ADDR_LED         = 16'hC000;   // {led1 rgb, led0 rgb}
    localparam logic [ADDR_W-1:0] ADDR_BTN         = 16'hC004;   // Read only

    // Offsets are address bits 5:2
    localparam logic [OFFSET_W-1:0] OFF_MTIMECMP_LO = ADDR_MTIMECMP_LO[5:2];
    localparam logic [OFFSET_W-1:0] OFF_MTIMECMP_HI = ADDR_MTIMECMP_HI[5:2];
    localparam logic [OFFSET_W-1:0] OFF_MTIME_LO    = ADDR_MTIME_LO[5:2];
    localparam logic [OFFSET_W-1:0] OFF_MTIME_HI    = ADDR_MTIME_HI[5:2];
    localparam logic [OFFSET_W-1:0] OFF_LED         = ADDR_LED[5:2];
    localparam logic [OFFSET_W-1:0] OFF_BTN         = ADDR_BTN[5:2];
    // msip aliases mtimecmp_lo in bits 5:2, so it gets a free slot
    localparam logic [OFFSET_W-1:0] OFF_MSIP        = 4'h8;

    // Which block executes a queued request
    typedef enum logic [1:0] {
        TGT_ACLINT = 2'd0,
        TGT_GPIO   = 2'd1,
        TGT_NONE   = 2'd2   // Unmapped or misaligned, answered with error
    } periph_target_e;

endpackage : letc_pkg

`default_nettype wire

// ==== letc_matrix.sv ====
// LETC interconnect decoder: accepts bus requests, decodes the target and pushes queue entries
`default_nettype none
`timescale 1ns/10ps

module letc_matrix (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_req_valid,
    input  logic                            i_req_write,
    input  logic [letc_pkg::ADDR_W-1:0]     i_req_addr,
    input  logic [letc_pkg::DATA_W-1:0]     i_req_wdata,
    input  logic                            i_fifo_full,
    input  logic                            i_fifo_almost_full,
    output logic                            o_req_ready,
    output logic                            o_push,
    output letc_pkg::periph_target_e        o_target,
    output logic                            o_write,
    output logic [letc_pkg::OFFSET_W-1:0]   o_offset,
    output logic [letc_pkg::DATA_W-1:0]     o_wdata
);
    import letc_pkg::*;

    logic                   alive_q;    // Low only through reset
    logic                   accept;
    periph_target_e         dec_target;
    logic [OFFSET_W-1:0]    dec_offset;

    // A pending push already claims one slot
    assign o_req_ready = alive_q && (o_push ? !i_fifo_almost_full : !i_fifo_full);
    assign accept      = i_req_valid && o_req_ready;

    always_comb begin
        dec_target = TGT_NONE;  // Misaligned stays here
        if (i_req_addr[1:0] == 2'b00) begin
            case (i_req_addr)
                ADDR_MSIP, ADDR_MTIMECMP_LO, ADDR_MTIMECMP_HI,
                ADDR_MTIME_LO, ADDR_MTIME_HI: dec_target = TGT_ACLINT;
                ADDR_LED, ADDR_BTN:           dec_target = TGT_GPIO;
                default:                      dec_target = TGT_NONE;
            endcase
        end
    end

    assign dec_offset = (i_req_addr == ADDR_MSIP) ? OFF_MSIP : i_req_addr[5:2];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            alive_q <= 1'b0;
            o_push  <= 1'b0;
        end else begin
            alive_q <= 1'b1;
            o_push  <= accept;  // Push one cycle after acceptance
        end
    end

    // Entry payload
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_target <= dec_target;
            o_write  <= i_req_write;
            o_offset <= dec_offset;
            o_wdata  <= i_req_wdata;
        end
    end

endmodule : letc_matrix

`default_nettype wire

// ==== letc_req_fifo.sv ====
// LETC request queue: circular FIFO of decoded requests between the decoder and the port
`default_nettype none
`timescale 1ns/10ps

module letc_req_fifo #(
    parameter int FIFO_DEPTH = 4    // Power of two, at least 2
) (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_push,
    input  letc_pkg::periph_target_e        i_target,
    input  logic                            i_write,
    input  logic [letc_pkg::OFFSET_W-1:0]   i_offset,
    input  logic [letc_pkg::DATA_W-1:0]     i_wdata,
    input  logic                            i_pop,
    output letc_pkg::periph_target_e        o_target,
    output logic                            o_write,
    output logic [letc_pkg::OFFSET_W-1:0]   o_offset,
    output logic [letc_pkg::DATA_W-1:0]     o_wdata,
    output logic                            o_empty,
    output logic                            o_full,
    output logic                            o_almost_full
);
    import letc_pkg::*;

    localparam int              PTR_W    = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0]  FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

    periph_target_e         target_mem [FIFO_DEPTH];
    logic                   write_mem  [FIFO_DEPTH];
    logic [OFFSET_W-1:0]    offset_mem [FIFO_DEPTH];
    logic [DATA_W-1:0]      wdata_mem  [FIFO_DEPTH];

    logic [PTR_W-1:0]   wr_ptr, rd_ptr;    // Wrap on their own
    logic [PTR_W:0]     count;
    logic               wr_en, rd_en;

    assign rd_en = i_pop && !o_empty;
    assign wr_en = i_push && (!o_full || rd_en);   // Full but draining is fine

    assign o_empty       = (count == '0);
    assign o_full        = (count == FULL_CNT);
    assign o_almost_full = (count >= FULL_CNT - 1'b1);   // Includes full

    // Head entry
    assign o_target = target_mem[rd_ptr];
    assign o_write  = write_mem[rd_ptr];
    assign o_offset = offset_mem[rd_ptr];
    assign o_wdata  = wdata_mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            target_mem[wr_ptr] <= i_target;
            write_mem[wr_ptr]  <= i_write;
            offset_mem[wr_ptr] <= i_offset;
            wdata_mem[wr_ptr]  <= i_wdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

endmodule : letc_req_fifo

`default_nettype wire

// ==== letc_aclint.sv ====
// LETC ACLINT: machine timer counter, timer compare and software interrupt registers
`default_nettype none
`timescale 1ns/10ps

module letc_aclint (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_access,
    input  logic                            i_write,
    input  logic [letc_pkg::OFFSET_W-1:0]   i_offset,
    input  logic [letc_pkg::DATA_W-1:0]     i_wdata,
    output logic [letc_pkg::DATA_W-1:0]     o_rdata,
    output logic                            o_timer_irq,
    output logic                            o_soft_irq
);
    import letc_pkg::*;

    logic [63:0]    mtime_q;
    logic [63:0]    mtimecmp_q;
    logic           msip_q;
    logic           wr;

    assign wr = i_access && i_write;

    // Counter; a written half replaces that half and counting resumes from it
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mtime_q <= '0;
        end else if (wr && (i_offset == OFF_MTIME_LO)) begin
            mtime_q <= {mtime_q[63:32], i_wdata};
        end else if (wr && (i_offset == OFF_MTIME_HI)) begin
            mtime_q <= {i_wdata, mtime_q[31:0]};
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mtimecmp_q <= '1;   // Never fires out of reset
            msip_q     <= 1'b0;
        end else if (wr) begin
            case (i_offset)
                OFF_MTIMECMP_LO: mtimecmp_q[31:0]  <= i_wdata;
                OFF_MTIMECMP_HI: mtimecmp_q[63:32] <= i_wdata;
                OFF_MSIP:        msip_q            <= i_wdata[0];
                default:         msip_q            <= msip_q;  // mtime or unused
            endcase
        end
    end

    // Interrupt lines, one cycle behind the registers
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_timer_irq <= 1'b0;
            o_soft_irq  <= 1'b0;
        end else begin
            o_timer_irq <= (mtime_q >= mtimecmp_q);
            o_soft_irq  <= msip_q;
        end
    end

    // Read mux
    always_comb begin
        case (i_offset)
            OFF_MSIP:        o_rdata = {{(DATA_W-1){1'b0}}, msip_q};
            OFF_MTIMECMP_LO: o_rdata = mtimecmp_q[31:0];
            OFF_MTIMECMP_HI: o_rdata = mtimecmp_q[63:32];
            OFF_MTIME_LO:    o_rdata = mtime_q[31:0];
            OFF_MTIME_HI:    o_rdata = mtime_q[63:32];
            default:         o_rdata = '0;
        endcase
    end

endmodule : letc_aclint

`default_nettype wire

// ==== letc_gpio.sv ====
// LETC GPIO block with the LED drive register and synchronized button status
`default_nettype none
`timescale 1ns/10ps

module letc_gpio (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_access,
    input  logic                            i_write,
    input  logic [letc_pkg::OFFSET_W-1:0]   i_offset,
    input  logic [letc_pkg::DATA_W-1:0]     i_wdata,
    input  logic [1:0]                      i_btn,
    output logic [letc_pkg::DATA_W-1:0]     o_rdata,
    output logic                            o_led0_r,
    output logic                            o_led0_g,
    output logic                            o_led0_b,
    output logic                            o_led1_r,
    output logic                            o_led1_g,
    output logic                            o_led1_b
);
    import letc_pkg::*;

    logic [5:0] led_q;      // {led1 r,g,b, led0 r,g,b}
    logic [1:0] btn_meta_q;
    logic [1:0] btn_sync_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            led_q      <= '0;   // All off
            btn_meta_q <= '0;
            btn_sync_q <= '0;
        end else begin
            if (i_access && i_write && (i_offset == OFF_LED))
                led_q <= i_wdata[5:0];  // Button writes dropped
            btn_meta_q <= i_btn;        // Two-flop synchronizer
            btn_sync_q <= btn_meta_q;
        end
    end

    assign {o_led1_r, o_led1_g, o_led1_b, o_led0_r, o_led0_g, o_led0_b} = led_q;

    always_comb begin
        case (i_offset)
            OFF_LED: o_rdata = {{(DATA_W-6){1'b0}}, led_q};
            OFF_BTN: o_rdata = {{(DATA_W-2){1'b0}}, btn_sync_q};
            default: o_rdata = '0;
        endcase
    end

endmodule : letc_gpio

`default_nettype wire

// ==== letc_periph_port.sv ====
// LETC peripheral port: pops queued requests, runs them on ACLINT or GPIO and holds the response
`default_nettype none
`timescale 1ns/10ps

module letc_periph_port (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_empty,
    input  letc_pkg::periph_target_e        i_target,
    input  logic                            i_write,
    input  logic [letc_pkg::OFFSET_W-1:0]   i_offset,
    input  logic [letc_pkg::DATA_W-1:0]     i_wdata,
    input  logic                            i_rsp_ready,
    input  logic [1:0]                      i_btn,
    output logic                            o_pop,
    output logic                            o_rsp_valid,
    output logic [letc_pkg::DATA_W-1:0]     o_rsp_rdata,
    output logic                            o_rsp_error,
    output logic                            o_timer_irq,
    output logic                            o_soft_irq,
    output logic                            o_led0_r,
    output logic                            o_led0_g,
    output logic                            o_led0_b,
    output logic                            o_led1_r,
    output logic                            o_led1_g,
    output logic                            o_led1_b
);
    import letc_pkg::*;

    logic               aclint_access, gpio_access;
    logic [DATA_W-1:0]  aclint_rdata, gpio_rdata;
    logic [DATA_W-1:0]  sel_rdata;

    // Pop only if the response slot is free or draining now
    assign o_pop         = !i_empty && (!o_rsp_valid || i_rsp_ready);
    assign aclint_access = o_pop && (i_target == TGT_ACLINT);
    assign gpio_access   = o_pop && (i_target == TGT_GPIO);

    letc_aclint aclint_i (
        .i_clk, .i_rst,
        .i_access(aclint_access),
        .i_write, .i_offset, .i_wdata,
        .o_rdata(aclint_rdata),
        .o_timer_irq, .o_soft_irq
    );

    letc_gpio gpio_i (
        .i_clk, .i_rst,
        .i_access(gpio_access),
        .i_write, .i_offset, .i_wdata, .i_btn,
        .o_rdata(gpio_rdata),
        .o_led0_r, .o_led0_g, .o_led0_b,
        .o_led1_r, .o_led1_g, .o_led1_b
    );

    always_comb begin
        case (i_target)
            TGT_ACLINT: sel_rdata = aclint_rdata;
            TGT_GPIO:   sel_rdata = gpio_rdata;
            default:    sel_rdata = '0;     // Error path reads zero
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst)
            o_rsp_valid <= 1'b0;
        else if (o_pop)
            o_rsp_valid <= 1'b1;    // Valid the cycle after the pop
        else if (i_rsp_ready)
            o_rsp_valid <= 1'b0;
    end

    // Response payload
    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            o_rsp_rdata <= i_write ? '0 : sel_rdata;
            o_rsp_error <= (i_target == TGT_NONE);
        end
    end

endmodule : letc_periph_port

`default_nettype wire

// ==== letc_top.sv ====
// LETC peripheral subsystem top: request decoder, request queue and peripheral port
`default_nettype none
`timescale 1ns/10ps

module letc_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_req_valid,
    input  logic                            i_req_write,
    input  logic [letc_pkg::ADDR_W-1:0]     i_req_addr,
    input  logic [letc_pkg::DATA_W-1:0]     i_req_wdata,
    input  logic                            i_rsp_ready,
    input  logic [1:0]                      i_btn,
    output logic                            o_req_ready,
    output logic                            o_rsp_valid,
    output logic [letc_pkg::DATA_W-1:0]     o_rsp_rdata,
    output logic                            o_rsp_error,
    output logic                            o_led0_r,
    output logic                            o_led0_g,
    output logic                            o_led0_b,
    output logic                            o_led1_r,
    output logic                            o_led1_g,
    output logic                            o_led1_b,
    output logic                            o_timer_irq,
    output logic                            o_soft_irq
);
    import letc_pkg::*;

    // Decoder to queue
    logic                   push;
    periph_target_e         push_target;
    logic                   push_write;
    logic [OFFSET_W-1:0]    push_offset;
    logic [DATA_W-1:0]      push_wdata;
    logic                   fifo_full, fifo_almost_full;

    // Queue head to port
    logic                   pop, fifo_empty;
    periph_target_e         head_target;
    logic                   head_write;
    logic [OFFSET_W-1:0]    head_offset;
    logic [DATA_W-1:0]      head_wdata;

    letc_matrix matrix_i (
        .i_clk, .i_rst,
        .i_req_valid, .i_req_write, .i_req_addr, .i_req_wdata,
        .i_fifo_full(fifo_full),
        .i_fifo_almost_full(fifo_almost_full),
        .o_req_ready,
        .o_push(push), .o_target(push_target), .o_write(push_write),
        .o_offset(push_offset), .o_wdata(push_wdata)
    );

    letc_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
        .i_clk, .i_rst,
        .i_push(push), .i_target(push_target), .i_write(push_write),
        .i_offset(push_offset), .i_wdata(push_wdata),
        .i_pop(pop),
        .o_target(head_target), .o_write(head_write),
        .o_offset(head_offset), .o_wdata(head_wdata),
        .o_empty(fifo_empty), .o_full(fifo_full), .o_almost_full(fifo_almost_full)
    );

    letc_periph_port periph_i (
        .i_clk, .i_rst,
        .i_empty(fifo_empty), .i_target(head_target), .i_write(head_write),
        .i_offset(head_offset), .i_wdata(head_wdata),
        .i_rsp_ready, .i_btn,
        .o_pop(pop),
        .o_rsp_valid, .o_rsp_rdata, .o_rsp_error,
        .o_timer_irq, .o_soft_irq,
        .o_led0_r, .o_led0_g, .o_led0_b,
        .o_led1_r, .o_led1_g, .o_led1_b
    );

endmodule : letc_top

`default_nettype wire

// ==== tb_letc_checker.sv ====
// LETC testbench checker with the register model, in-order response comparison and test report
`default_nettype none
`timescale 1ns/10ps

module tb_letc_checker #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_req_valid,
    input  logic                            i_req_ready,
    input  logic                            i_req_write,
    input  logic [letc_pkg::ADDR_W-1:0]     i_req_addr,
    input  logic [letc_pkg::DATA_W-1:0]     i_req_wdata,
    input  logic                            i_rsp_valid,
    input  logic                            i_rsp_ready,
    input  logic [letc_pkg::DATA_W-1:0]     i_rsp_rdata,
    input  logic                            i_rsp_error,
    input  logic [1:0]                      i_btn,
    input  logic [5:0]                      i_led,      // {led1 r,g,b, led0 r,g,b}
    input  logic                            i_timer_irq,
    input  logic                            i_soft_irq,
    input  logic                            i_out_chk,  // Outputs checked after writes
    input  logic [2:0]                      i_test_id,
    input  logic                            i_test_done,
    input  logic                            i_all_done,
    output int                              o_pending,
    output int                              o_errors
);
    import letc_pkg::*;

    logic               wr_q    [$];    // Outstanding requests in arrival order
    logic [ADDR_W-1:0]  addr_q  [$];
    logic [DATA_W-1:0]  wdata_q [$];
    int                 cyc_q   [$];    // Cycle of acceptance

    logic [5:0]     led_m;
    logic           msip_m;
    logic [63:0]    cmp_m;
    logic [31:0]    mt_base;            // Lower bound of mtime at base_cyc
    int             mt_base_cyc;
    logic [31:0]    mt_last;
    logic           mt_last_ok;
    int             cyc, delay;
    int             checks = 0, errors = 0, err_mark = 0, passed = 0, failed = 0;

    // Expected {error, rdata} from the register map
    function automatic logic [32:0] ref_rsp(input logic wr, input logic [ADDR_W-1:0] addr,
                                            input logic [1:0] btn);
        logic [31:0]    rd;
        logic           err;
        rd  = 32'd0;
        err = 1'b0;
        case (addr)
            ADDR_LED:         rd = {26'd0, led_m};
            ADDR_BTN:         rd = {30'd0, btn};
            ADDR_MSIP:        rd = {31'd0, msip_m};
            ADDR_MTIMECMP_LO: rd = cmp_m[31:0];
            ADDR_MTIMECMP_HI: rd = cmp_m[63:32];
            ADDR_MTIME_HI:    rd = 32'd0;       // Counter never leaves the low word
            ADDR_MTIME_LO:    rd = 32'd0;       // Bound check instead
            default:          err = 1'b1;       // Unmapped or misaligned
        endcase
        if (wr || err)
            rd = 32'd0;
        return {err, rd};
    endfunction

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "gpio";
            3'd2:    return "software irq";
            3'd3:    return "timer";
            3'd4:    return "errors";
            default: return "backpressure and ordering";
        endcase
    endfunction

    task automatic report_err(input string msg);
        errors++;
        $display("error %0t: %s", $time, msg);
    endtask

    task automatic report_other(input string msg);
        errors++;
        $display("%s (at %0t)", msg, $time);
    endtask

    always @(posedge i_clk) begin : compare
        logic               wr;
        logic [ADDR_W-1:0]  addr;
        logic [DATA_W-1:0]  wdata;
        int                 acc;
        logic [32:0]        want;
        logic [31:0]        low;
        if (i_rst) begin
            led_m      = '0;
            msip_m     = 1'b0;
            cmp_m      = '1;    // Compare all ones out of reset
            mt_base    = '0;
            mt_base_cyc = 0;
            mt_last_ok = 1'b0;
            cyc        = 0;     // Tracks mtime exactly until a write
            delay      = 0;
            wr_q.delete();
            addr_q.delete();
            wdata_q.delete();
            cyc_q.delete();
        end else begin
            if (cyc == 0) begin
                checks++;
                if (i_req_ready || i_rsp_valid || (i_led != 6'd0) || i_timer_irq || i_soft_irq)
                    report_err("outputs not idle right after reset");
            end
            if (delay != 0) begin
                delay--;
                if (delay == 0) begin   // Three cycles after a write response
                    checks++;
                    // mtime stays far below every compare value used except zero
                    if ((i_led !== led_m) || (i_soft_irq !== msip_m) ||
                        (i_timer_irq !== (cmp_m == 64'd0)))
                        report_err($sformatf("led %b soft %b timer %b, expected %b %b %b",
                            i_led, i_soft_irq, i_timer_irq, led_m, msip_m, cmp_m == 64'd0));
                end
            end
            if (i_rsp_valid && i_rsp_ready) begin
                if (addr_q.size() == 0) begin
                    report_other("response arrived with no request outstanding");
                end else begin
                    wr    = wr_q.pop_front();
                    addr  = addr_q.pop_front();
                    wdata = wdata_q.pop_front();
                    acc   = cyc_q.pop_front();
                    want  = ref_rsp(wr, addr, i_btn);
                    checks++;
                    if (!wr && (addr == ADDR_MTIME_LO)) begin
                        low = mt_base + 32'(acc - mt_base_cyc);
                        if (i_rsp_error || (i_rsp_rdata < low) ||
                            (mt_last_ok && (i_rsp_rdata <= mt_last)))
                            report_err($sformatf("mtime_lo read %h, floor %h, previous %h",
                                i_rsp_rdata, low, mt_last));
                        mt_last    = i_rsp_rdata;
                        mt_last_ok = 1'b1;
                    end else if ({i_rsp_error, i_rsp_rdata} !== want) begin
                        report_err($sformatf("%s %h gave err %b data %h, expected %b %h",
                            wr ? "write" : "read", addr, i_rsp_error, i_rsp_rdata,
                            want[32], want[31:0]));
                    end
                    if (wr) begin
                        case (addr)
                            ADDR_LED:         led_m = wdata[5:0];
                            ADDR_MSIP:        msip_m = wdata[0];
                            ADDR_MTIMECMP_LO: cmp_m[31:0] = wdata;
                            ADDR_MTIMECMP_HI: cmp_m[63:32] = wdata;
                            ADDR_MTIME_LO: begin
                                mt_base     = wdata;
                                mt_base_cyc = cyc;
                                mt_last_ok  = 1'b0;
                            end
                            default: ;      // Button and error writes change nothing
                        endcase
                        if (i_out_chk)
                            delay = 3;
                    end
                end
            end
            if (i_req_valid && i_req_ready) begin
                wr_q.push_back(i_req_write);
                addr_q.push_back(i_req_addr);
                wdata_q.push_back(i_req_wdata);
                cyc_q.push_back(cyc);
                if (addr_q.size() > FIFO_DEPTH + 2)     // Decoder, queue, response slot
                    report_other("more requests taken than the decoder, queue and port can hold");
            end
            if (i_test_done) begin
                if (errors == err_mark)
                    passed++;
                else
                    failed++;
                $display("test %0d %s: %s, %0d errors", i_test_id, test_name(i_test_id),
                    (errors == err_mark) ? "pass" : "FAIL", errors - err_mark);
                err_mark = errors;
            end
            if (i_all_done)
                $display("tests passed %0d failed %0d, checks %0d, errors %0d",
                    passed, failed, checks, errors);
            cyc++;
        end
        o_pending <= addr_q.size();
        o_errors  <= errors;
    end

endmodule : tb_letc_checker

`default_nettype wire

// ==== tb_letc_top.sv ====
// LETC testbench top with clock, reset, directed and random bus traffic and a run limit
`default_nettype none
`timescale 1ns/10ps

module tb_letc_top;
    import letc_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int N_RAND     = 40;
    localparam int N_REQ      = 30 + FIFO_DEPTH + 3 + N_RAND;  // Directed, stall, random
    localparam int MAX_CYCLES = 20 * N_REQ + 200;

    logic               clk, rst;
    logic               req_valid, req_write, rsp_ready;
    logic [ADDR_W-1:0]  req_addr;
    logic [DATA_W-1:0]  req_wdata;
    logic [1:0]         btn;
    logic               req_ready, rsp_valid, rsp_error;
    logic [DATA_W-1:0]  rsp_rdata;
    logic [5:0]         led;                    // {led1 r,g,b, led0 r,g,b}
    logic               timer_irq, soft_irq;
    logic               out_chk, rand_rdy, test_done, all_done;
    logic [2:0]         test_id;
    logic               pick_wr;
    logic [ADDR_W-1:0]  pick_addr;
    logic [31:0]        rng;
    int                 pending, errors, n_acc;
    int                 cycles = 0;

    letc_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut_i (
        .i_clk(clk), .i_rst(rst),
        .i_req_valid(req_valid), .i_req_write(req_write),
        .i_req_addr(req_addr), .i_req_wdata(req_wdata),
        .i_rsp_ready(rsp_ready), .i_btn(btn),
        .o_req_ready(req_ready), .o_rsp_valid(rsp_valid),
        .o_rsp_rdata(rsp_rdata), .o_rsp_error(rsp_error),
        .o_led0_r(led[2]), .o_led0_g(led[1]), .o_led0_b(led[0]),
        .o_led1_r(led[5]), .o_led1_g(led[4]), .o_led1_b(led[3]),
        .o_timer_irq(timer_irq), .o_soft_irq(soft_irq)
    );

    tb_letc_checker #(.FIFO_DEPTH(FIFO_DEPTH)) checker_i (
        .i_clk(clk), .i_rst(rst),
        .i_req_valid(req_valid), .i_req_ready(req_ready), .i_req_write(req_write),
        .i_req_addr(req_addr), .i_req_wdata(req_wdata),
        .i_rsp_valid(rsp_valid), .i_rsp_ready(rsp_ready),
        .i_rsp_rdata(rsp_rdata), .i_rsp_error(rsp_error),
        .i_btn(btn), .i_led(led), .i_timer_irq(timer_irq), .i_soft_irq(soft_irq),
        .i_out_chk(out_chk), .i_test_id(test_id), .i_test_done(test_done),
        .i_all_done(all_done), .o_pending(pending), .o_errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Hold one request until taken and optionally draw a random rsp_ready each cycle
    task automatic send_req(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= data;
        do begin
            if (rand_rdy) begin
                rng = lcg_next(rng);
                rsp_ready <= rng[16];
            end
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
    endtask

    // One request, its response, then room for the delayed output check
    task automatic do_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
        send_req(wr, addr, data);
        do @(posedge clk); while (!(rsp_valid && rsp_ready));
        repeat (4) @(posedge clk);
    endtask

    task automatic finish_test(input logic [2:0] id);
        test_id   <= id;
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
        @(posedge clk);
    endtask

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        rsp_ready = 1'b1;
        btn       = 2'b00;
        out_chk   = 1'b1;
        rand_rdy  = 1'b0;
        test_done = 1'b0;
        all_done  = 1'b0;
        test_id   = 3'd0;
        rng       = 32'd79;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < 4; i++) begin   // LED write and read back
            rng = lcg_next(rng);
            do_xfer(1'b1, ADDR_LED, rng);
            do_xfer(1'b0, ADDR_LED, '0);
        end
        btn <= 2'b10;
        repeat (4) @(posedge clk);          // Through the synchronizer
        do_xfer(1'b0, ADDR_BTN, '0);
        btn <= 2'b01;
        repeat (4) @(posedge clk);
        do_xfer(1'b0, ADDR_BTN, '0);
        finish_test(3'd1);

        do_xfer(1'b1, ADDR_MSIP, 32'd1);
        do_xfer(1'b0, ADDR_MSIP, '0);
        do_xfer(1'b1, ADDR_MSIP, 32'd0);
        do_xfer(1'b0, ADDR_MSIP, '0);
        finish_test(3'd2);

        do_xfer(1'b0, ADDR_MTIME_LO, '0);
        do_xfer(1'b0, ADDR_MTIME_LO, '0);
        do_xfer(1'b1, ADDR_MTIMECMP_LO, 32'd0);
        do_xfer(1'b1, ADDR_MTIMECMP_HI, 32'd0);     // Timer fires here
        do_xfer(1'b0, ADDR_MTIMECMP_LO, '0);
        do_xfer(1'b1, ADDR_MTIMECMP_LO, '1);
        do_xfer(1'b1, ADDR_MTIMECMP_HI, '1);
        do_xfer(1'b1, ADDR_MTIME_LO, 32'h0000_1000);
        do_xfer(1'b0, ADDR_MTIME_LO, '0);
        do_xfer(1'b0, ADDR_MTIME_LO, '0);
        finish_test(3'd3);

        do_xfer(1'b1, 16'h1000, 32'h3F);    // Unmapped
        do_xfer(1'b1, 16'hC001, 32'h3F);    // Misaligned LED
        do_xfer(1'b0, 16'h1000, '0);
        do_xfer(1'b0, 16'h4002, '0);
        do_xfer(1'b0, ADDR_LED, '0);        // Still the old value
        do_xfer(1'b1, ADDR_BTN, 32'h3);
        finish_test(3'd4);

        // Stall the response side and fill everything
        out_chk   <= 1'b0;
        rsp_ready <= 1'b0;
        req_valid <= 1'b1;
        req_write <= 1'b0;
        req_addr  <= ADDR_MSIP;
        n_acc = 0;
        do begin
            @(posedge clk);
            if (req_ready)
                n_acc++;
        end while (req_ready && (n_acc <= FIFO_DEPTH + 2));
        req_valid <= 1'b0;
        rand_rdy = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            rng = lcg_next(rng);
            case (rng[18:16])
                3'd0:    pick_addr = ADDR_LED;
                3'd1:    pick_addr = ADDR_BTN;
                3'd2:    pick_addr = ADDR_MSIP;
                3'd3:    pick_addr = ADDR_MTIMECMP_LO;
                3'd4:    pick_addr = ADDR_MTIMECMP_HI;
                3'd5:    pick_addr = ADDR_MTIME_LO;
                3'd6:    pick_addr = 16'h2000;      // Unmapped
                default: pick_addr = 16'hC006;      // Misaligned
            endcase
            pick_wr = rng[20] && (pick_addr != ADDR_MTIME_LO);  // Counter only read here
            rng = lcg_next(rng);
            send_req(pick_wr, pick_addr, rng);
        end
        do begin                            // Drain what is still queued
            rng = lcg_next(rng);
            rsp_ready <= rng[16];
            @(posedge clk);
        end while (pending != 0);
        rsp_ready <= 1'b1;
        rand_rdy = 1'b0;
        finish_test(3'd5);

        all_done <= 1'b1;
        @(posedge clk);
        all_done <= 1'b0;
        @(posedge clk);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule : tb_letc_top

`default_nettype wire

// ==== files.f ====
letc_pkg.sv
letc_matrix.sv
letc_req_fifo.sv
letc_aclint.sv
letc_gpio.sv
letc_periph_port.sv
letc_top.sv
tb_letc_checker.sv
tb_letc_top.sv
